/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert --top-module cpu_soc_tb \
		-f cpu_soc_top.f --Mdir obj_dir -o cpu_soc_sim
	@out=$$(./obj_dir/cpu_soc_sim 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

/* cpu_soc_top.f */
rtl/cpu_pkg.sv
rtl/axi_read_port.sv
rtl/axi_write_port.sv
rtl/core_ctrl.sv
rtl/cpu_soc_top.sv
dv/cpu_soc_assertions.sv
dv/cpu_soc_tb.sv

/* dv/cpu_soc_assertions.sv */
`timescale 1ns/1ns
module cpu_soc_assertions (
  input logic        clock,
  input logic        arst_n,
  input logic        io_master_arvalid,
  input logic        io_master_arready,
  input logic [31:0] io_master_araddr,
  input logic [7:0]  io_master_arlen,
  input logic        io_master_awvalid,
  input logic        io_master_awready,
  input logic [31:0] io_master_awaddr,
  input logic        io_master_wvalid,
  input logic        io_master_wready,
  input logic [63:0] io_master_wdata,
  input logic        io_master_wlast
);

  ar_stable: assert property (@(posedge clock) disable iff (!arst_n)
    io_master_arvalid && !io_master_arready |=>
      io_master_arvalid && $stable(io_master_araddr))
    else $error("arvalid dropped or araddr changed before arready");

  aw_stable: assert property (@(posedge clock) disable iff (!arst_n)
    io_master_awvalid && !io_master_awready |=>
      io_master_awvalid && $stable(io_master_awaddr))
    else $error("awvalid dropped or awaddr changed before awready");

  w_stable: assert property (@(posedge clock) disable iff (!arst_n)
    io_master_wvalid && !io_master_wready |=>
      io_master_wvalid && $stable(io_master_wdata))
    else $error("wvalid dropped or wdata changed before wready");

  arlen_zero: assert property (@(posedge clock) disable iff (!arst_n)
    io_master_arvalid |-> io_master_arlen == 8'd0)
    else $error("arlen is not zero");

  wlast_set: assert property (@(posedge clock) disable iff (!arst_n)
    io_master_wvalid |-> io_master_wlast)
    else $error("wvalid without wlast");

endmodule

bind cpu_soc_top cpu_soc_assertions cpu_soc_assertions_i (.*);

/* dv/cpu_soc_tb.sv */
`timescale 1ns/1ns
module cpu_soc_tb;
  import cpu_pkg::*;

  localparam int NSTORES = 9;
  localparam int NPROG   = 25;
  localparam int TIMEOUT = 400;
  localparam int LD_READ = 18; // fetches 0 to 17 come before the load

  logic clock, arst_n;
  logic awready, wready, bvalid, arready, rvalid, rlast;
  logic [1:0] bresp, rresp;
  logic [3:0] bid, rid;
  logic [63:0] rdata;
  logic awvalid, wvalid, bready, arvalid, rready, wlast, halted;
  logic [31:0] awaddr, araddr;
  logic [3:0] awid, arid;
  logic [7:0] awlen, arlen, wstrb;
  logic [2:0] awsize, arsize;
  logic [1:0] awburst, arburst;
  logic [63:0] wdata;

  logic [31:0] mem [256];
  logic [31:0] prog [NPROG];
  logic [31:0] exp_addr [NSTORES];
  logic [31:0] exp_data [NSTORES];
  logic [7:0]  exp_strb [NSTORES];
  axi_ar_t ar_log [$];
  axi_aw_t aw_log [$];
  axi_w_t  w_log [$];
  integer seed = 32'h6985_d5f0;

  // slave side state
  logic ar_hs, r_hs, aw_hs, w_hs, b_hs;
  logic r_pend, b_pend, aw_got, w_got;
  logic [31:0] r_addr, aw_addr_s;
  axi_w_t w_s;
  int ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt, base, cycles;

  cpu_soc_top cpu_soc_top_i (
    .clock(clock), .arst_n(arst_n),
    .io_master_awready(awready), .io_master_awvalid(awvalid), .io_master_awaddr(awaddr),
    .io_master_awid(awid), .io_master_awlen(awlen), .io_master_awsize(awsize),
    .io_master_awburst(awburst), .io_master_wready(wready), .io_master_wvalid(wvalid),
    .io_master_wdata(wdata), .io_master_wstrb(wstrb), .io_master_wlast(wlast),
    .io_master_bready(bready), .io_master_bvalid(bvalid), .io_master_bresp(bresp),
    .io_master_bid(bid), .io_master_arready(arready), .io_master_arvalid(arvalid),
    .io_master_araddr(araddr), .io_master_arid(arid), .io_master_arlen(arlen),
    .io_master_arsize(arsize), .io_master_arburst(arburst), .io_master_rready(rready),
    .io_master_rvalid(rvalid), .io_master_rresp(rresp), .io_master_rdata(rdata),
    .io_master_rlast(rlast), .io_master_rid(rid), .halted(halted)
  );

  always #20 clock = ~clock;

  function automatic logic [31:0] enc(opcode_t op, logic [2:0] rd, logic [2:0] rs,
                                      logic [15:0] imm);
    return {op, rd, rs, 6'b0, imm};
  endfunction

  function automatic int delay_pick();
    return $unsigned($random(seed)) % 4; // 0 to 3 cycles
  endfunction

  task automatic fail_stop(string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_ar(string name, axi_ar_t exp, axi_ar_t act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      fail_stop("read address phase differs");
    end
  endtask

  task automatic check_aw(string name, axi_aw_t exp, axi_aw_t act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      fail_stop("write address phase differs");
    end
  endtask

  task automatic check_w(string name, axi_w_t exp, axi_w_t act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      fail_stop("write data phase differs");
    end
  endtask

  task automatic check_halt(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
      fail_stop("halted flag differs");
    end
  endtask

  // handshakes seen at the rising edge
  always @(posedge clock) begin
    ar_hs <= arst_n && arvalid && arready;
    r_hs  <= arst_n && rvalid && rready;
    aw_hs <= arst_n && awvalid && awready;
    w_hs  <= arst_n && wvalid && wready;
    b_hs  <= arst_n && bvalid && bready;
    if (arst_n && arvalid && arready) begin
      r_addr <= araddr;
      ar_log.push_back(axi_ar_t'({araddr, arid, arlen, arsize, arburst}));
    end
    if (arst_n && awvalid && awready) begin
      aw_addr_s <= awaddr;
      aw_log.push_back(axi_aw_t'({awaddr, awid, awlen, awsize, awburst}));
    end
    if (arst_n && wvalid && wready) begin
      w_s <= '{wdata, wstrb, wlast};
      w_log.push_back(axi_w_t'({wdata, wstrb, wlast}));
    end
  end

  // memory slave, driven on the falling edge
  always @(negedge clock) begin
    if (arst_n) begin
      if (ar_hs) begin
        arready = 1'b0;
        ar_cnt  = delay_pick();
        r_pend  = 1'b1;
        r_cnt   = delay_pick();
      end else if (arvalid && !arready) begin
        if (ar_cnt == 0) arready = 1'b1;
        else ar_cnt--;
      end
      if (r_hs) begin
        rvalid = 1'b0;
        r_pend = 1'b0;
      end else if (r_pend && !rvalid) begin
        if (r_cnt == 0) begin
          base   = {24'b0, r_addr[9:3], 1'b0};
          rdata  = {mem[base+1], mem[base]};
          rvalid = 1'b1;
        end else r_cnt--;
      end
      if (aw_hs) begin
        awready = 1'b0;
        aw_cnt  = delay_pick();
        aw_got  = 1'b1;
      end else if (awvalid && !awready) begin
        if (aw_cnt == 0) awready = 1'b1;
        else aw_cnt--;
      end
      if (w_hs) begin
        wready = 1'b0;
        w_cnt  = delay_pick();
        w_got  = 1'b1;
      end else if (wvalid && !wready) begin
        if (w_cnt == 0) wready = 1'b1;
        else w_cnt--;
      end
      if (aw_got && w_got) begin
        base = {24'b0, aw_addr_s[9:3], 1'b0};
        if (w_s.wstrb[3:0] != 0) mem[base] = w_s.wdata[31:0];
        if (w_s.wstrb[7:4] != 0) mem[base+1] = w_s.wdata[63:32];
        aw_got = 1'b0;
        w_got  = 1'b0;
        b_pend = 1'b1;
        b_cnt  = delay_pick();
      end
      if (b_hs) begin
        bvalid = 1'b0;
        b_pend = 1'b0;
      end else if (b_pend && !bvalid) begin
        if (b_cnt == 0) bvalid = 1'b1;
        else b_cnt--;
      end
    end
  end

  initial begin
    clock = 1'b0;
    arst_n = 1'b0;
    {awready, wready, bvalid, arready, rvalid} = '0;
    {bresp, bid, rresp, rid, rdata} = '0;
    rlast = 1'b1;
    {r_pend, b_pend, aw_got, w_got} = '0;
    {ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt} = '0;

    prog = '{enc(OP_ADDI, 1, 0, 12), enc(OP_ADDI, 2, 0, 10),
             enc(OP_ADDI, 3, 1, 0), enc(OP_ADD, 3, 2, 0), enc(OP_ST, 3, 0, 16'h100),
             enc(OP_ADDI, 3, 1, 0), enc(OP_SUB, 3, 2, 0), enc(OP_ST, 3, 0, 16'h108),
             enc(OP_ADDI, 3, 1, 0), enc(OP_AND, 3, 2, 0), enc(OP_ST, 3, 0, 16'h110),
             enc(OP_ADDI, 3, 1, 0), enc(OP_OR, 3, 2, 0), enc(OP_ST, 3, 0, 16'h118),
             enc(OP_ADDI, 3, 1, 0), enc(OP_XOR, 3, 2, 0), enc(OP_ST, 3, 0, 16'h120),
             enc(OP_LD, 4, 0, 16'h200), enc(OP_ADDI, 4, 4, 16'h11),
             enc(OP_ST, 4, 0, 16'h124),
             enc(OP_ADDI, 5, 0, 3), enc(OP_ST, 5, 0, 16'h130),  // loop from 3 down
             enc(OP_ADDI, 5, 5, 16'hFFFF), enc(OP_BNEZ, 5, 0, 16'hFFFE),
             enc(OP_HALT, 0, 0, 0)};
    exp_addr = '{32'h100, 32'h108, 32'h110, 32'h118, 32'h120, 32'h124,
                 32'h130, 32'h130, 32'h130};
    exp_data = '{32'd22, 32'd2, 32'd8, 32'd14, 32'd6, 32'h1234_5689,
                 32'd3, 32'd2, 32'd1};
    exp_strb = '{8'h0F, 8'h0F, 8'h0F, 8'h0F, 8'h0F, 8'hF0,
                 8'h0F, 8'h0F, 8'h0F};

    for (int i = 0; i < 256; i++) mem[i] = 32'hDEAD_0000 ^ (i * 32'h0101_0001);
    for (int i = 0; i < NPROG; i++) mem[i] = prog[i];
    mem[32'h200 >> 2] = 32'h1234_5678;

    repeat (5) @(negedge clock);
    arst_n = 1'b1;

    for (int i = 0; i < NSTORES; i++) begin
      cycles = 0;
      while (aw_log.size() <= i || w_log.size() <= i) begin
        @(negedge clock);
        cycles++;
        if (cycles > TIMEOUT) fail_stop($sformatf("timeout waiting for store %0d", i));
      end
      check_aw($sformatf("store %0d aw", i),
               axi_aw_t'({exp_addr[i], 4'd0, 8'd0, 3'd2, 2'b01}), aw_log[i]);
      check_w($sformatf("store %0d w", i),
              axi_w_t'({exp_data[i], exp_data[i], exp_strb[i], 1'b1}), w_log[i]);
      check_halt($sformatf("store %0d halted", i), 1'b0, halted);
    end

    check_ar("reset fetch ar", axi_ar_t'({32'h0, 4'd0, 8'd0, 3'd2, 2'b01}), ar_log[0]);
    check_ar("load ar", axi_ar_t'({32'h200, 4'd0, 8'd0, 3'd2, 2'b01}), ar_log[LD_READ]);

    cycles = 0;
    while (halted !== 1'b1) begin
      @(negedge clock);
      cycles++;
      if (cycles > TIMEOUT) fail_stop("timeout waiting for halted after HALT");
    end

    // core must stay quiet once halted
    repeat (50) begin
      @(negedge clock);
      check_halt("halt held", 1'b1, halted);
      if (arvalid) fail_stop("read address issued after halt");
    end
    if (aw_log.size() != NSTORES) fail_stop("extra writes seen after the last store");

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* rtl/axi_read_port.sv */
`timescale 1ns/1ns
module axi_read_port (
  input  logic                 clock,
  input  logic                 arst_n,
  input  logic                 rd_valid,
  input  cpu_pkg::mem_rd_req_t rd_req,
  output logic                 rd_done,
  output cpu_pkg::mem_rd_rsp_t rd_rsp,
  output logic                 arvalid,
  output cpu_pkg::axi_ar_t     ar,
  input  logic                 arready,
  input  logic                 rvalid,
  input  cpu_pkg::axi_r_t      r,
  output logic                 rready
);
  import cpu_pkg::*;

  typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_t;

  rd_state_t   state;
  logic [31:0] addr_q;

  // single beat, 4 bytes, id 0
  assign ar = '{araddr: addr_q, arid: AXI_ID, arlen: 8'd0,
                arsize: AXI_SIZE_4B, arburst: AXI_BURST_INCR};

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state   <= RD_IDLE;
      arvalid <= 1'b0;
      rready  <= 1'b0;
      rd_done <= 1'b0;
    end else begin
      rd_done <= 1'b0;
      case (state)
        RD_IDLE: if (rd_valid && !rd_done) begin // core still holds valid during done
          arvalid <= 1'b1;
          state   <= RD_ADDR;
        end
        RD_ADDR: if (arready) begin
          arvalid <= 1'b0;
          rready  <= 1'b1;
          state   <= RD_DATA;
        end
        RD_DATA: if (rvalid) begin
          rready  <= 1'b0;
          rd_done <= 1'b1;
          state   <= RD_IDLE;
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == RD_IDLE && rd_valid) addr_q <= rd_req.addr;
    if (state == RD_DATA && rvalid) begin
      rd_rsp.data <= addr_q[2] ? r.rdata[63:32] : r.rdata[31:0]; // word lane by addr bit 2
      rd_rsp.err  <= (r.rresp != AXI_RESP_OKAY);
    end
  end

endmodule

/* rtl/axi_write_port.sv */
`timescale 1ns/1ns
module axi_write_port (
  input  logic                 clock,
  input  logic                 arst_n,
  input  logic                 wr_valid,
  input  cpu_pkg::mem_wr_req_t wr_req,
  output logic                 wr_done,
  output logic                 awvalid,
  output cpu_pkg::axi_aw_t     aw,
  input  logic                 awready,
  output logic                 wvalid,
  output cpu_pkg::axi_w_t      w,
  input  logic                 wready,
  input  logic                 bvalid,
  input  cpu_pkg::axi_b_t      b,
  output logic                 bready
);
  import cpu_pkg::*;

  typedef enum logic [1:0] {WR_IDLE, WR_REQ, WR_RESP} wr_state_t;

  wr_state_t   state;
  mem_wr_req_t req_q;
  logic        aw_fin;
  logic        w_fin;

  assign aw = '{awaddr: req_q.addr, awid: AXI_ID, awlen: 8'd0,
                awsize: AXI_SIZE_4B, awburst: AXI_BURST_INCR};

  // word copied to both lanes, strobe picks the lane
  assign w = '{wdata: {req_q.data, req_q.data},
               wstrb: req_q.addr[2] ? 8'hF0 : 8'h0F,
               wlast: 1'b1};

  // each phase is finished once its handshake has been seen
  assign aw_fin = !awvalid || awready;
  assign w_fin  = !wvalid || wready;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state   <= WR_IDLE;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b0;
      wr_done <= 1'b0;
    end else begin
      wr_done <= 1'b0;
      case (state)
        WR_IDLE: if (wr_valid && !wr_done) begin
          awvalid <= 1'b1;
          wvalid  <= 1'b1;
          state   <= WR_REQ;
        end
        WR_REQ: begin
          if (awready) awvalid <= 1'b0;
          if (wready) wvalid <= 1'b0;
          if (aw_fin && w_fin) begin // AW and W in either order
            bready <= 1'b1;
            state  <= WR_RESP;
          end
        end
        WR_RESP: if (bvalid) begin
          bready  <= 1'b0;
          wr_done <= 1'b1;
          state   <= WR_IDLE;
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == WR_IDLE && wr_valid) req_q <= wr_req;
  end

endmodule

/* rtl/core_ctrl.sv */
`timescale 1ns/1ns
module core_ctrl #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic                 clock,
  input  logic                 arst_n,
  output logic                 rd_valid,
  output cpu_pkg::mem_rd_req_t rd_req,
  input  logic                 rd_done,
  input  cpu_pkg::mem_rd_rsp_t rd_rsp,
  output logic                 wr_valid,
  output cpu_pkg::mem_wr_req_t wr_req,
  input  logic                 wr_done,
  output logic                 halted
);
  import cpu_pkg::*;

  core_state_t     state;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] regs [NREGS];
  instr_t          ir;
  logic [XLEN-1:0] op_s;   // rs value
  logic [XLEN-1:0] op_d;   // rd value
  logic [XLEN-1:0] imm_x;  // sign-extended imm
  logic [XLEN-1:0] alu_res;
  logic            alu_op;
  logic            rf_we;
  logic [XLEN-1:0] rf_wd;

  always_comb begin
    case (ir.opcode)
      OP_ADDI: alu_res = op_s + imm_x;
      OP_ADD:  alu_res = op_d + op_s;
      OP_SUB:  alu_res = op_d - op_s;
      OP_AND:  alu_res = op_d & op_s;
      OP_OR:   alu_res = op_d | op_s;
      OP_XOR:  alu_res = op_d ^ op_s;
      default: alu_res = op_s + imm_x; // effective address for LD/ST
    endcase
  end

  assign alu_op = ir.opcode inside {OP_ADDI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};

  // r0 is never written
  assign rf_we = (ir.rd != '0) &&
                 ((state == EXEC && alu_op) ||
                  (state == MEM_RD && rd_done && !rd_rsp.err));
  assign rf_wd = (state == MEM_RD) ? rd_rsp.data : alu_res;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state    <= FETCH;
      pc       <= RESET_PC;
      rd_valid <= 1'b0;
      wr_valid <= 1'b0;
      halted   <= 1'b0;
    end else begin
      case (state)
        FETCH: begin
          if (!rd_valid) begin
            rd_valid <= 1'b1;
          end else if (rd_done) begin
            rd_valid <= 1'b0;
            halted   <= rd_rsp.err; // bus error on fetch stops the core
            state    <= rd_rsp.err ? HALTED : DECODE;
          end
        end
        DECODE: state <= EXEC;
        EXEC: begin
          case (ir.opcode)
            OP_ADDI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
              pc    <= pc + 32'd4;
              state <= FETCH;
            end
            OP_LD: begin
              rd_valid <= 1'b1;
              state    <= MEM_RD;
            end
            OP_ST: begin
              wr_valid <= 1'b1;
              state    <= MEM_WR;
            end
            OP_BNEZ: begin
              pc    <= (op_d != '0) ? pc + (imm_x << 2) : pc + 32'd4;
              state <= FETCH;
            end
            default: begin // HALT and unused codes
              halted <= 1'b1;
              state  <= HALTED;
            end
          endcase
        end
        MEM_RD: if (rd_done) begin
          rd_valid <= 1'b0;
          halted   <= rd_rsp.err;
          pc       <= pc + 32'd4;
          state    <= rd_rsp.err ? HALTED : FETCH;
        end
        MEM_WR: if (wr_done) begin
          wr_valid <= 1'b0;
          pc       <= pc + 32'd4;
          state    <= FETCH;
        end
        HALTED: state <= HALTED;
        default: state <= HALTED;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == FETCH && !rd_valid) rd_req.addr <= pc;
    if (state == FETCH && rd_done) ir <= instr_t'(rd_rsp.data);
    if (state == DECODE) begin
      op_s  <= (ir.rs == '0) ? '0 : regs[ir.rs];
      op_d  <= (ir.rd == '0) ? '0 : regs[ir.rd];
      imm_x <= {{(XLEN-IMM_W){ir.imm[IMM_W-1]}}, ir.imm};
    end
    if (state == EXEC) begin
      rd_req.addr <= alu_res; // only used when LD
      wr_req      <= '{addr: alu_res, data: op_d};
    end
    if (rf_we) regs[ir.rd] <= rf_wd;
  end

endmodule

/* rtl/cpu_pkg.sv */
package cpu_pkg;

  localparam int XLEN  = 32;
  localparam int NREGS = 8;
  localparam int OPC_W = 4;
  localparam int REG_W = 3;
  localparam int IMM_W = 16;
  localparam int PAD_W = XLEN - OPC_W - 2 * REG_W - IMM_W; // unused middle bits

  localparam logic [3:0] AXI_ID         = 4'd0;
  localparam logic [2:0] AXI_SIZE_4B    = 3'd2;
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;
  localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

  typedef enum logic [OPC_W-1:0] {
    OP_ADDI = 4'h0, // rd = rs + imm
    OP_ADD  = 4'h1, // rd = rd + rs
    OP_SUB  = 4'h2, // rd = rd - rs
    OP_AND  = 4'h3,
    OP_OR   = 4'h4,
    OP_XOR  = 4'h5,
    OP_LD   = 4'h6, // rd = mem[rs + imm]
    OP_ST   = 4'h7, // mem[rs + imm] = rd
    OP_BNEZ = 4'h8, // pc += imm * 4 if rd != 0
    OP_HALT = 4'h9
  } opcode_t;

  typedef enum logic [2:0] {
    FETCH, DECODE, EXEC, MEM_RD, MEM_WR, HALTED
  } core_state_t;

  typedef struct packed {
    opcode_t            opcode; // [31:28]
    logic [REG_W-1:0]   rd;     // [27:25]
    logic [REG_W-1:0]   rs;     // [24:22]
    logic [PAD_W-1:0]   pad;
    logic [IMM_W-1:0]   imm;    // signed
  } instr_t;

  typedef struct packed {
    logic [31:0] addr;
  } mem_rd_req_t;

  typedef struct packed {
    logic [31:0] data;
    logic        err;  // rresp not OKAY
  } mem_rd_rsp_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } mem_wr_req_t;

  typedef struct packed {
    logic [31:0] araddr;
    logic [3:0]  arid;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic [1:0]  arburst;
  } axi_ar_t;

  typedef struct packed {
    logic [31:0] awaddr;
    logic [3:0]  awid;
    logic [7:0]  awlen;
    logic [2:0]  awsize;
    logic [1:0]  awburst;
  } axi_aw_t;

  typedef struct packed {
    logic [63:0] wdata;
    logic [7:0]  wstrb;
    logic        wlast;
  } axi_w_t;

  typedef struct packed {
    logic [63:0] rdata;
    logic [1:0]  rresp;
    logic        rlast;
    logic [3:0]  rid;
  } axi_r_t;

  typedef struct packed {
    logic [1:0] bresp;
    logic [3:0] bid;
  } axi_b_t;

endpackage

/* rtl/cpu_soc_top.sv */
`timescale 1ns/1ns
module cpu_soc_top #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic        clock,
  input  logic        arst_n,
  input  logic        io_master_awready,
  output logic        io_master_awvalid,
  output logic [31:0] io_master_awaddr,
  output logic [3:0]  io_master_awid,
  output logic [7:0]  io_master_awlen,
  output logic [2:0]  io_master_awsize,
  output logic [1:0]  io_master_awburst,
  input  logic        io_master_wready,
  output logic        io_master_wvalid,
  output logic [63:0] io_master_wdata,
  output logic [7:0]  io_master_wstrb,
  output logic        io_master_wlast,
  output logic        io_master_bready,
  input  logic        io_master_bvalid,
  input  logic [1:0]  io_master_bresp,
  input  logic [3:0]  io_master_bid,
  input  logic        io_master_arready,
  output logic        io_master_arvalid,
  output logic [31:0] io_master_araddr,
  output logic [3:0]  io_master_arid,
  output logic [7:0]  io_master_arlen,
  output logic [2:0]  io_master_arsize,
  output logic [1:0]  io_master_arburst,
  output logic        io_master_rready,
  input  logic        io_master_rvalid,
  input  logic [1:0]  io_master_rresp,
  input  logic [63:0] io_master_rdata,
  input  logic        io_master_rlast,
  input  logic [3:0]  io_master_rid,
  output logic        halted
);
  import cpu_pkg::*;

  axi_ar_t     ar;
  axi_aw_t     aw;
  axi_w_t      w;
  axi_r_t      r;
  axi_b_t      b;
  logic        rd_valid;
  mem_rd_req_t rd_req;
  logic        rd_done;
  mem_rd_rsp_t rd_rsp;
  logic        wr_valid;
  mem_wr_req_t wr_req;
  logic        wr_done;

  // master inputs
  assign r = '{rdata: io_master_rdata, rresp: io_master_rresp,
               rlast: io_master_rlast, rid: io_master_rid};
  assign b = '{bresp: io_master_bresp, bid: io_master_bid};

  // master outputs
  assign io_master_araddr  = ar.araddr;
  assign io_master_arid    = ar.arid;
  assign io_master_arlen   = ar.arlen;
  assign io_master_arsize  = ar.arsize;
  assign io_master_arburst = ar.arburst;
  assign io_master_awaddr  = aw.awaddr;
  assign io_master_awid    = aw.awid;
  assign io_master_awlen   = aw.awlen;
  assign io_master_awsize  = aw.awsize;
  assign io_master_awburst = aw.awburst;
  assign io_master_wdata   = w.wdata;
  assign io_master_wstrb   = w.wstrb;
  assign io_master_wlast   = w.wlast;

  core_ctrl #(
    .RESET_PC(RESET_PC)
  ) core_ctrl_i (
    .clock   (clock),
    .arst_n  (arst_n),
    .rd_valid(rd_valid),
    .rd_req  (rd_req),
    .rd_done (rd_done),
    .rd_rsp  (rd_rsp),
    .wr_valid(wr_valid),
    .wr_req  (wr_req),
    .wr_done (wr_done),
    .halted  (halted)
  );

  axi_read_port axi_read_port_i (
    .clock   (clock),
    .arst_n  (arst_n),
    .rd_valid(rd_valid),
    .rd_req  (rd_req),
    .rd_done (rd_done),
    .rd_rsp  (rd_rsp),
    .arvalid (io_master_arvalid),
    .ar      (ar),
    .arready (io_master_arready),
    .rvalid  (io_master_rvalid),
    .r       (r),
    .rready  (io_master_rready)
  );

  axi_write_port axi_write_port_i (
    .clock   (clock),
    .arst_n  (arst_n),
    .wr_valid(wr_valid),
    .wr_req  (wr_req),
    .wr_done (wr_done),
    .awvalid (io_master_awvalid),
    .aw      (aw),
    .awready (io_master_awready),
    .wvalid  (io_master_wvalid),
    .w       (w),
    .wready  (io_master_wready),
    .bvalid  (io_master_bvalid),
    .b       (b),
    .bready  (io_master_bready)
  );

endmodule
